// ==== verilog/pipe_pkg.sv ====
/* Pipeline package
   Instruction formats, operation codes and the decode and writeback records */
package pipe_pkg;

   // Register number width, set by the 5-bit instruction fields
   localparam int RF_ADDR_WIDTH = 5;
   localparam int IMM_WIDTH     = 18;
   // Widest operand the writeback record can carry
   localparam int WB_DATA_WIDTH = 64;

   typedef enum logic [3:0] {
      NOP  = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      AND  = 4'd3,
      OR   = 4'd4,
      XOR  = 4'd5,
      ADDI = 4'd6,
      MOVI = 4'd7
   } opcode_e;

   // Register-register format
   typedef struct packed {
      opcode_e                  opcode;
      logic [RF_ADDR_WIDTH-1:0] rd;
      logic [RF_ADDR_WIDTH-1:0] ra;
      logic [RF_ADDR_WIDTH-1:0] rb;
      logic [12:0]              pad;
   } r_fmt_t;

   // Register-immediate format
   typedef struct packed {
      opcode_e                  opcode;
      logic [RF_ADDR_WIDTH-1:0] rd;
      logic [RF_ADDR_WIDTH-1:0] ra;
      logic [IMM_WIDTH-1:0]     imm;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } insn_u;

   typedef struct packed {
      opcode_e                  opcode;
      logic [RF_ADDR_WIDTH-1:0] rd;
      logic                     use_imm;
      logic [IMM_WIDTH-1:0]     imm;
      logic                     wb;
   } dec_op_t;

   // Low OPERAND_WIDTH bits of data are meaningful
   typedef struct packed {
      logic [RF_ADDR_WIDTH-1:0] rd;
      logic [WB_DATA_WIDTH-1:0] data;
   } wb_t;

endpackage

// ==== verilog/rf_ram.sv ====
/* Register file RAM copy
   32 words, synchronous write and registered read */
`timescale 1ns/10ps

module rf_ram #(
   parameter int OPERAND_WIDTH = 32
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [pipe_pkg::RF_ADDR_WIDTH-1:0] rdad_i,
   input  logic                               rden_i,
   output logic [OPERAND_WIDTH-1:0]           rdda_o,
   input  logic [pipe_pkg::RF_ADDR_WIDTH-1:0] wrad_i,
   input  logic                               wren_i,
   input  logic [OPERAND_WIDTH-1:0]           wrda_i
);

   import pipe_pkg::*;

   logic [OPERAND_WIDTH-1:0] mem [0:(1 << RF_ADDR_WIDTH)-1];

   // Write port, contents undefined until written
   always_ff @(posedge clk) begin
      if (wren_i) begin
         mem[wrad_i] <= wrda_i;
      end
   end

   // Read port returns the old word on a same-edge write
   always_ff @(posedge clk) begin
      if (rst) begin
         rdda_o <= '0;
      end else if (rden_i) begin
         rdda_o <= mem[rdad_i];
      end
   end

endmodule

// ==== verilog/rf_regfile.sv ====
/* Register file with two read ports and one write port
   Two RAM copies plus a last-write bypass for same-edge read and write */
`timescale 1ns/10ps

module rf_regfile #(
   parameter int OPERAND_WIDTH = 32
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               rd_en_i,
   input  logic [pipe_pkg::RF_ADDR_WIDTH-1:0] rfa_adr_i,
   input  logic [pipe_pkg::RF_ADDR_WIDTH-1:0] rfb_adr_i,
   input  pipe_pkg::wb_t                      wb_i,
   input  logic                               we_i,
   output logic [OPERAND_WIDTH-1:0]           rfa_o,
   output logic [OPERAND_WIDTH-1:0]           rfb_o
);

   import pipe_pkg::*;

   logic [OPERAND_WIDTH-1:0] rfa_ram;
   logic [OPERAND_WIDTH-1:0] rfb_ram;
   logic [OPERAND_WIDTH-1:0] wr_data;

   // Read numbers of the instruction now in execute
   logic [RF_ADDR_WIDTH-1:0] rfa_r;
   logic [RF_ADDR_WIDTH-1:0] rfb_r;

   // Bypass record of the most recent write
   logic                     last_vld;
   logic [RF_ADDR_WIDTH-1:0] last_rd;
   logic [OPERAND_WIDTH-1:0] last_data;

   logic rfa_use_last;
   logic rfb_use_last;

   assign wr_data = wb_i.data[OPERAND_WIDTH-1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         rfa_r <= '0;
         rfb_r <= '0;
      end else if (rd_en_i) begin
         rfa_r <= rfa_adr_i;
         rfb_r <= rfb_adr_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         last_vld  <= 1'b0;
         last_rd   <= '0;
         last_data <= '0;
      end else if (we_i) begin
         last_vld  <= 1'b1;
         last_rd   <= wb_i.rd;
         last_data <= wr_data;
      end
   end

   // Older writes are already in RAM, only the last one can collide
   assign rfa_use_last = last_vld && (last_rd == rfa_r);
   assign rfb_use_last = last_vld && (last_rd == rfb_r);

   assign rfa_o = rfa_use_last ? last_data : rfa_ram;
   assign rfb_o = rfb_use_last ? last_data : rfb_ram;

   rf_ram #(
      .OPERAND_WIDTH(OPERAND_WIDTH)
   ) u_rfa (
      .clk   (clk),
      .rst   (rst),
      .rdad_i(rfa_adr_i),
      .rden_i(rd_en_i),
      .rdda_o(rfa_ram),
      .wrad_i(wb_i.rd),
      .wren_i(we_i),
      .wrda_i(wr_data)
   );

   rf_ram #(
      .OPERAND_WIDTH(OPERAND_WIDTH)
   ) u_rfb (
      .clk   (clk),
      .rst   (rst),
      .rdad_i(rfb_adr_i),
      .rden_i(rd_en_i),
      .rdda_o(rfb_ram),
      .wrad_i(wb_i.rd),
      .wren_i(we_i),
      .wrda_i(wr_data)
   );

   // Execute stage must hand over a fully known write
   a_wr_known: assert property (@(posedge clk) disable iff (rst)
      we_i |-> !$isunknown({wb_i.rd, wr_data}));

endmodule

// ==== verilog/insn_decode.sv ====
/* Instruction decoder
   Splits the instruction word into register numbers, immediate and operation */
`timescale 1ns/10ps

module insn_decode (
   input  pipe_pkg::insn_u                    insn_i,
   output logic [pipe_pkg::RF_ADDR_WIDTH-1:0] rfa_adr_o,
   output logic [pipe_pkg::RF_ADDR_WIDTH-1:0] rfb_adr_o,
   output pipe_pkg::dec_op_t                  op_o
);

   import pipe_pkg::*;

   opcode_e opc;

   // Opcode sits in the same place in both formats
   assign opc = insn_i.r.opcode;

   always_comb begin
      rfa_adr_o  = insn_i.r.ra;
      rfb_adr_o  = '0;
      op_o.opcode  = NOP;
      op_o.rd      = insn_i.r.rd;
      op_o.use_imm = 1'b0;
      op_o.imm     = '0;
      op_o.wb      = 1'b0;

      case (opc)
         ADD, SUB, AND, OR, XOR: begin
            // R view, second operand from rb
            rfb_adr_o   = insn_i.r.rb;
            op_o.opcode = opc;
            op_o.wb     = 1'b1;
         end
         ADDI, MOVI: begin
            // I view, second operand is the immediate
            op_o.opcode  = opc;
            op_o.use_imm = 1'b1;
            op_o.imm     = insn_i.i.imm;
            op_o.wb      = 1'b1;
         end
         default: begin
            // NOP and unused codes write nothing
            op_o.opcode = NOP;
            op_o.wb     = 1'b0;
         end
      endcase
   end

endmodule

// ==== verilog/alu_execute.sv ====
/* Execute stage
   ALU on the register operands or immediate, result registered for writeback */
`timescale 1ns/10ps

module alu_execute #(
   parameter int OPERAND_WIDTH = 32
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid_i,
   input  pipe_pkg::dec_op_t        op_i,
   input  logic [OPERAND_WIDTH-1:0] rfa_i,
   input  logic [OPERAND_WIDTH-1:0] rfb_i,
   output pipe_pkg::wb_t            wb_o,
   output logic                     we_o
);

   import pipe_pkg::*;

   logic [OPERAND_WIDTH-1:0] imm_ext;
   logic [OPERAND_WIDTH-1:0] opb;
   logic [OPERAND_WIDTH-1:0] result;

   // Sign-extend the 18-bit immediate
   assign imm_ext = OPERAND_WIDTH'($signed(op_i.imm));

   assign opb = op_i.use_imm ? imm_ext : rfb_i;

   // Arithmetic wraps at OPERAND_WIDTH
   always_comb begin
      case (op_i.opcode)
         ADD, ADDI: result = rfa_i + opb;
         SUB:       result = rfa_i - opb;
         AND:       result = rfa_i & opb;
         OR:        result = rfa_i | opb;
         XOR:       result = rfa_i ^ opb;
         MOVI:      result = imm_ext;
         default:   result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         we_o <= 1'b0;
      end else begin
         we_o <= valid_i && op_i.wb;
      end
   end

   // Result and destination
   always_ff @(posedge clk) begin
      if (valid_i) begin
         wb_o.rd   <= op_i.rd;
         wb_o.data <= WB_DATA_WIDTH'(result);
      end
   end

   // Decoder clears the writeback flag for NOP
   a_nop_no_we: assert property (@(posedge clk) disable iff (rst)
      (valid_i && op_i.opcode == NOP) |=> !we_o);

endmodule

// ==== verilog/pipe_top.sv ====
/* Three-stage pipeline top
   Four-phase instruction handshake, decode register, execute and writeback */
`timescale 1ns/10ps

module pipe_top #(
   parameter int OPERAND_WIDTH = 32
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            insn_req_i,
   input  pipe_pkg::insn_u insn_i,
   output logic            insn_ack_o,
   output logic            wb_valid_o,
   output pipe_pkg::wb_t   wb_o
);

   import pipe_pkg::*;

   logic                     accept;
   logic [RF_ADDR_WIDTH-1:0] rfa_adr;
   logic [RF_ADDR_WIDTH-1:0] rfb_adr;
   dec_op_t                  dec_op;
   dec_op_t                  dec_op_r;
   logic                     dec_valid;
   logic [OPERAND_WIDTH-1:0] rfa;
   logic [OPERAND_WIDTH-1:0] rfb;
   wb_t                      ex_wb;
   logic                     ex_we;

   // New request while ack is low
   assign accept = insn_req_i && !insn_ack_o;

   always_ff @(posedge clk) begin
      if (rst) begin
         insn_ack_o <= 1'b0;
      end else if (accept) begin
         insn_ack_o <= 1'b1;
      end else if (!insn_req_i) begin
         insn_ack_o <= 1'b0;
      end
   end

   insn_decode u_insn_decode (
      .insn_i   (insn_i),
      .rfa_adr_o(rfa_adr),
      .rfb_adr_o(rfb_adr),
      .op_o     (dec_op)
   );

   // Decode stage register
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dec_op_r <= dec_op;
      end
   end

   rf_regfile #(
      .OPERAND_WIDTH(OPERAND_WIDTH)
   ) u_rf_regfile (
      .clk      (clk),
      .rst      (rst),
      .rd_en_i  (accept),
      .rfa_adr_i(rfa_adr),
      .rfb_adr_i(rfb_adr),
      .wb_i     (ex_wb),
      .we_i     (ex_we),
      .rfa_o    (rfa),
      .rfb_o    (rfb)
   );

   alu_execute #(
      .OPERAND_WIDTH(OPERAND_WIDTH)
   ) u_alu_execute (
      .clk    (clk),
      .rst    (rst),
      .valid_i(dec_valid),
      .op_i   (dec_op_r),
      .rfa_i  (rfa),
      .rfb_i  (rfb),
      .wb_o   (ex_wb),
      .we_o   (ex_we)
   );

   // Result port, same edge as the register file write
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid_o <= 1'b0;
      end else begin
         wb_valid_o <= ex_we;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_we) begin
         wb_o <= ex_wb;
      end
   end

   // Writing instruction pulses the result port in the cycle after E2
   a_wb_after_accept: assert property (@(posedge clk) disable iff (rst)
      (accept && dec_op.wb) |-> ##3 wb_valid_o);

endmodule

// ==== tb/pipe_checker.sv ====
/* Pipeline checker
   Models the registers from accepted instructions and checks results and handshake */
`timescale 1ns/10ps

module pipe_checker #(
   parameter int OPERAND_WIDTH = 32
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          insn_req_i,
   input  logic [31:0]   insn_i,
   input  logic          insn_ack_i,
   input  logic          wb_valid_i,
   input  pipe_pkg::wb_t wb_i,
   input  logic          end_i,
   output int            mismatch_cnt_o,
   output int            error_cnt_o,
   output int            pending_o
);

   localparam int          MAX_CASES = 64;
   localparam logic [31:0] NOP_MARK  = 32'hff;
   localparam logic [31:0] END_MARK  = 32'hee;

   logic [31:0]              case_mem [0:4*MAX_CASES-1];
   logic [OPERAND_WIDTH-1:0] regs [0:31];
   bit                       written [0:31];
   int                       n_cases;
   int                       n_file_writes;
   int                       n_acc;
   int                       n_pulses;
   int                       cycle;
   logic                     req_q;
   logic                     ack_q;
   logic                     rst_q;
   bit                       end_done;

   // Results still due, oldest first
   int                       q_case [$];
   int                       q_due [$];
   logic [4:0]               q_rd [$];
   logic [OPERAND_WIDTH-1:0] q_file [$];
   logic [OPERAND_WIDTH-1:0] q_model [$];

   initial begin
      mismatch_cnt_o = 0;
      error_cnt_o    = 0;
      pending_o      = 0;
      n_acc          = 0;
      n_pulses       = 0;
      cycle          = 0;
      req_q          = 1'b0;
      ack_q          = 1'b0;
      rst_q          = 1'b0;
      end_done       = 1'b0;
      for (int r = 0; r < 32; r++) begin
         written[r] = 1'b0;
      end
      $readmemh("tb/pipe_cases.txt", case_mem);
      n_cases       = 0;
      n_file_writes = 0;
      while (n_cases < MAX_CASES && case_mem[4*n_cases+1] != END_MARK) begin
         if (case_mem[4*n_cases+1] != NOP_MARK) begin
            n_file_writes++;
         end
         n_cases++;
      end
   end

   task automatic report_error(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      error_cnt_o++;
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
      mismatch_cnt_o++;
   endtask

   task automatic drop_front();
      void'(q_case.pop_front());
      void'(q_due.pop_front());
      void'(q_rd.pop_front());
      void'(q_file.pop_front());
      void'(q_model.pop_front());
   endtask

   // 18-bit immediate, upper bits copy bit 17
   function automatic logic [OPERAND_WIDTH-1:0] sign_extend_imm(input logic [17:0] imm);
      logic [OPERAND_WIDTH-1:0] v;
      v       = imm[17] ? '1 : '0;
      v[17:0] = imm;
      return v;
   endfunction

   // Result of a writing instruction from the register model
   function automatic logic [OPERAND_WIDTH-1:0] expected_result(input logic [31:0] w);
      logic [OPERAND_WIDTH-1:0] a;
      logic [OPERAND_WIDTH-1:0] b;
      logic [OPERAND_WIDTH-1:0] k;
      a = regs[w[22:18]];
      b = regs[w[17:13]];
      k = sign_extend_imm(w[17:0]);
      case (w[31:28])
         4'd1:    return a + b;
         4'd2:    return a - b;
         4'd3:    return a & b;
         4'd4:    return a | b;
         4'd5:    return a ^ b;
         4'd6:    return a + k;
         default: return k;
      endcase
   endfunction

   task automatic record_accept(input logic [31:0] w);
      logic [3:0]               op;
      logic [4:0]               rd;
      logic [31:0]              f_rd;
      logic [OPERAND_WIDTH-1:0] f_data;
      logic [OPERAND_WIDTH-1:0] res;
      op = w[31:28];
      rd = w[27:23];
      if (n_acc >= n_cases) begin
         report_error("instruction accepted beyond the end of the case file");
         return;
      end
      f_rd   = case_mem[4*n_acc+1];
      f_data = OPERAND_WIDTH'(case_mem[4*n_acc+2]);
      if (w !== case_mem[4*n_acc]) begin
         report_error($sformatf("case %0d accepted as %h, file has %h",
                                n_acc, w, case_mem[4*n_acc]));
      end
      if (op >= 4'd1 && op <= 4'd6 && !written[w[22:18]]) begin
         report_error($sformatf("case %0d reads r%0d before any write", n_acc, w[22:18]));
      end
      if (op >= 4'd1 && op <= 4'd5 && !written[w[17:13]]) begin
         report_error($sformatf("case %0d reads r%0d before any write", n_acc, w[17:13]));
      end
      if (op >= 4'd1 && op <= 4'd7) begin
         res = expected_result(w);
         if (f_rd != 32'(rd) || f_data != res) begin
            report_error($sformatf("case %0d: file expects r%0d = %h, model gives r%0d = %h",
                                   n_acc, f_rd, f_data, rd, res));
         end
         regs[rd]    = res;
         written[rd] = 1'b1;
         q_case.push_back(n_acc);
         // Pulse is seen at the third edge after acceptance
         q_due.push_back(cycle + 3);
         q_rd.push_back(rd);
         q_file.push_back(f_data);
         q_model.push_back(res);
      end else if (f_rd != NOP_MARK) begin
         report_error($sformatf("case %0d does not write but the file expects r%0d", n_acc, f_rd));
      end
      n_acc++;
   endtask

   always @(posedge clk) begin
      cycle++;
      if (rst_q && (insn_ack_i || wb_valid_i)) begin
         report_error("insn_ack_o or wb_valid_o high after a reset edge");
      end
      if (!rst) begin
         if (insn_ack_i && !ack_q && !req_q) begin
            report_error("insn_ack_o rose while insn_req_i was low");
         end
         if (!insn_ack_i && ack_q && req_q) begin
            report_error("insn_ack_o fell while insn_req_i was still high");
         end
         if (!rst_q && req_q && !ack_q && !insn_ack_i) begin
            report_error("insn_req_i was not acknowledged on the next edge");
         end

         if (q_due.size() > 0 && q_due[0] < cycle) begin
            report_error($sformatf("no wb_valid_o pulse for case %0d", q_case[0]));
            drop_front();
         end
         if (wb_valid_i) begin
            n_pulses++;
            if (q_due.size() == 0) begin
               report_error("wb_valid_o pulse with no result outstanding");
            end else begin
               if (q_due[0] != cycle) begin
                  report_error($sformatf("result of case %0d came %0d cycles early",
                                         q_case[0], q_due[0] - cycle));
               end
               if (wb_i.rd !== q_rd[0]) begin
                  report_mismatch("wb_o.rd", 64'(wb_i.rd), 64'(q_rd[0]));
               end
               if (wb_i.data[OPERAND_WIDTH-1:0] !== q_file[0]) begin
                  report_mismatch("wb_o.data", 64'(wb_i.data[OPERAND_WIDTH-1:0]),
                                  64'(q_file[0]));
               end
               if (wb_i.data[OPERAND_WIDTH-1:0] !== q_model[0]) begin
                  report_mismatch("wb_o.data vs model", 64'(wb_i.data[OPERAND_WIDTH-1:0]),
                                  64'(q_model[0]));
               end
               drop_front();
            end
         end

         if (insn_req_i && !insn_ack_i) begin
            record_accept(insn_i);
         end
      end

      if (end_i && !end_done) begin
         end_done = 1'b1;
         if (n_acc != n_cases) begin
            report_error($sformatf("only %0d of %0d cases were accepted", n_acc, n_cases));
         end
         if (n_pulses != n_file_writes) begin
            report_error($sformatf("%0d wb_valid_o pulses, %0d writing cases",
                                   n_pulses, n_file_writes));
         end
      end
      pending_o = q_due.size();
      req_q     = insn_req_i;
      ack_q     = insn_ack_i;
      rst_q     = rst;
   end

endmodule

// ==== tb/tb_pipe.sv ====
/* Pipeline testbench
   Sends the case file over the instruction handshake with random idle gaps */
`timescale 1ns/10ps

module tb_pipe;

   import pipe_pkg::*;

   localparam int          OPERAND_WIDTH = 32;
   localparam int          MAX_CASES     = 64;
   localparam int          WAIT_CYCLES   = 20;
   localparam logic [31:0] END_MARK      = 32'hee;
   localparam logic [31:0] RANDOM_GAP    = 32'hf;
   localparam int unsigned SEED          = 32'hc9eff8ad;

   logic  clk;
   logic  rst;
   logic  insn_req;
   insn_u insn;
   logic  insn_ack;
   logic  wb_valid;
   wb_t   wb;
   logic  run_end;

   // Four words per case: instruction, rd or marker, data, idle gap
   logic [31:0] case_mem [0:4*MAX_CASES-1];
   int          n_cases;
   int          tb_errors;
   int          mismatches;
   int          checker_errors;
   int          pending;
   int          waited;
   bit          timed_out;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   pipe_top #(
      .OPERAND_WIDTH(OPERAND_WIDTH)
   ) u_pipe_top (
      .clk       (clk),
      .rst       (rst),
      .insn_req_i(insn_req),
      .insn_i    (insn),
      .insn_ack_o(insn_ack),
      .wb_valid_o(wb_valid),
      .wb_o      (wb)
   );

   pipe_checker #(
      .OPERAND_WIDTH(OPERAND_WIDTH)
   ) u_pipe_checker (
      .clk           (clk),
      .rst           (rst),
      .insn_req_i    (insn_req),
      .insn_i        (insn),
      .insn_ack_i    (insn_ack),
      .wb_valid_i    (wb_valid),
      .wb_i          (wb),
      .end_i         (run_end),
      .mismatch_cnt_o(mismatches),
      .error_cnt_o   (checker_errors),
      .pending_o     (pending)
   );

   // Poll on falling edges until ack reaches the given level
   task automatic wait_ack(input logic level, input int idx);
      int n;
      n = 0;
      while (insn_ack !== level && n < WAIT_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (insn_ack !== level) begin
         $display("Timeout: insn_ack_o did not go to %0d for case %0d", level, idx);
         tb_errors++;
         timed_out = 1'b1;
      end
   endtask

   // One full four-phase transfer
   task automatic send_insn(input int idx);
      int idle;
      if (case_mem[4*idx+3] == RANDOM_GAP) begin
         idle = int'($urandom_range(3, 0));
      end else begin
         idle = int'(case_mem[4*idx+3]);
      end
      repeat (idle) @(negedge clk);
      insn     = case_mem[4*idx];
      insn_req = 1'b1;
      @(negedge clk);
      wait_ack(1'b1, idx);
      if (!timed_out) begin
         insn_req = 1'b0;
         @(negedge clk);
         wait_ack(1'b0, idx);
      end
   endtask

   initial begin
      insn_req  = 1'b0;
      insn      = '0;
      rst       = 1'b1;
      run_end   = 1'b0;
      tb_errors = 0;
      timed_out = 1'b0;
      void'($urandom(SEED));
      $readmemh("tb/pipe_cases.txt", case_mem);
      n_cases = 0;
      while (n_cases < MAX_CASES && case_mem[4*n_cases+1] != END_MARK) begin
         n_cases++;
      end
      if (n_cases == 0 || n_cases == MAX_CASES) begin
         $display("Case file tb/pipe_cases.txt is missing or has no end marker");
         tb_errors++;
      end

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < n_cases && !timed_out && tb_errors == 0; i++) begin
         send_insn(i);
      end

      // Let the last results come out
      waited = 0;
      while (pending != 0 && waited < WAIT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (pending != 0) begin
         $display("Timeout: %0d results still outstanding at the end", pending);
         tb_errors++;
      end
      // Quiet period, any pulse here is extra
      repeat (8) @(negedge clk);
      run_end = 1'b1;
      @(negedge clk);

      $display("Errors: %0d mismatches, %0d checker errors, %0d testbench errors",
               mismatches, checker_errors, tb_errors);
      if (mismatches == 0 && checker_errors == 0 && tb_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== tb/pipe_cases.txt ====
// Columns: instruction word, rd (ff = no write, ee = end), expected data, idle gap
// Gap f picks 0 to 3 idle cycles at random before the request
70800123 01 00000123 f  // movi r1, 0x123
7103fffb 02 fffffffb f  // movi r2, -5
7181ffff 03 0001ffff f  // movi r3, largest positive
72020000 04 fffe0000 f  // movi r4, most negative
62840010 05 00000133 f  // addi r5, r1, 0x10
13044000 06 0000011e f  // add r6, r1, r2
23886000 07 fffdfffc f  // sub r7, r2, r3
34086000 08 0001fffb f  // and r8, r2, r3
408c8000 01 ffffffff f  // or r1, r3, r4
5114c000 02 0000002d f  // xor r2, r5, r6
11842000 03 fffffffe f  // add r3, r1, r1 wraps
620c0003 04 00000001 0  // addi r4, r3, 3 bypass on ra
22888000 05 0000002c 0  // sub r5, r2, r4 bypass on rb
1314a000 06 00000058 0  // add r6, r5, r5 bypass on both
2398a000 07 0000002c 1  // sub r7, r6, r5 one idle cycle
00000000 ff 00000000 f  // nop
f1234567 ff 00000000 0  // unused opcode acts as nop
641fffff 08 0000002b 0  // addi r8, r7, -1 after nops
70000abc 00 00000abc f  // movi r0, r0 is ordinary
30010000 00 00000028 0  // and r0, r0, r8
7f82aaaa 1f fffeaaaa f  // movi r31, negative pattern
5f7c0000 1e fffeaa82 0  // xor r30, r31, r0
00000000 ff 00000000 f  // nop
00000000 ee 00000000 0  // end of cases

// ==== all.f ====
verilog/pipe_pkg.sv
verilog/rf_ram.sv
verilog/rf_regfile.sv
verilog/insn_decode.sv
verilog/alu_execute.sv
verilog/pipe_top.sv
tb/pipe_checker.sv
tb/tb_pipe.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_pipe
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
